// ==== source/core_defines.svh ====
// Width, depth and count macros for the register machine core
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////
// Datapath
`define CORE_DATA_WIDTH      16
`define CORE_REG_COUNT       16
`define CORE_REG_ADDR_WIDTH  4

////////////////////////////////////////
// Instruction format
`define CORE_OPCODE_WIDTH    4
`define CORE_INSTR_WIDTH     24

////////////////////////////////////////
// Program store and issue path
`define CORE_STORE_DEPTH     64
`define CORE_PC_WIDTH        6
// Queue slots, also the credit count after reset
`define CORE_QUEUE_DEPTH     4

`endif

// ==== source/core_pkg.sv ====
// Opcode enumeration, instruction word union, issue and result records
`include "core_defines.svh"

package core_pkg;

    // Values 8 to 14 are illegal
    typedef enum logic [`CORE_OPCODE_WIDTH-1:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        SHL  = 4'd6,
        LDI  = 4'd7,
        HALT = 4'd15
    } opcode_t;

    // Register form, used by every opcode except LDI
    typedef struct packed {
        logic [`CORE_OPCODE_WIDTH-1:0]   opcode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_REG_ADDR_WIDTH-1:0] src_a;
        logic [`CORE_REG_ADDR_WIDTH-1:0] src_b;
        logic [`CORE_INSTR_WIDTH-`CORE_OPCODE_WIDTH-3*`CORE_REG_ADDR_WIDTH-1:0] unused;
    } reg_form_t;

    // Immediate form, LDI only
    typedef struct packed {
        logic [`CORE_OPCODE_WIDTH-1:0]   opcode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_DATA_WIDTH-1:0]     immediate;
    } imm_form_t;

    // Opcode and dest sit at the same bits in both views
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } instruction_t;

    typedef struct packed {
        logic         valid;
        instruction_t word;
    } issue_t;

    typedef struct packed {
        logic                            valid;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_DATA_WIDTH-1:0]     data;
    } result_t;

endpackage

// ==== source/instruction_store.sv ====
// Program memory with a load write port and a registered fetch read
`include "core_defines.svh"

module instruction_store (
    input  logic                      clock,
    input  logic                      load_valid,
    input  logic [`CORE_PC_WIDTH-1:0] load_address,
    input  core_pkg::instruction_t    load_word,
    input  logic [`CORE_PC_WIDTH-1:0] fetch_address,
    output core_pkg::instruction_t    fetch_word
);

    ////////////////////////////////////////
    // Storage

    core_pkg::instruction_t memory [`CORE_STORE_DEPTH];

    ////////////////////////////////////////
    // Load port

    // One word per cycle, only written while the core is idle
    always_ff @(posedge clock) begin
        if (load_valid) begin
            memory[load_address] <= load_word;
        end
    end

    ////////////////////////////////////////
    // Fetch port

    // Registered read, the word appears one cycle after its address
    always_ff @(posedge clock) begin
        fetch_word <= memory[fetch_address];
    end

endmodule

// ==== source/control_unit.sv ====
// Control unit with run control, program counter, credit counter and instruction issue
`include "core_defines.svh"

module control_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      run,
    output logic [`CORE_PC_WIDTH-1:0] fetch_address,
    input  core_pkg::instruction_t    fetch_word,
    input  logic                      credit_return,
    output core_pkg::issue_t          issue
);

    localparam int CREDIT_WIDTH = $clog2(`CORE_QUEUE_DEPTH + 1);

    logic                      running;
    logic                      fetch_valid;
    logic [`CORE_PC_WIDTH-1:0] pc;
    logic [CREDIT_WIDTH-1:0]   credits;
    logic                      fire;
    logic                      fire_halt;

    ////////////////////////////////////////
    // Issue

    // pc is the address of the word now held in fetch_word
    assign fire      = running && fetch_valid && (credits != '0);
    assign fire_halt = fire && (fetch_word.reg_form.opcode == core_pkg::HALT);

    // Request the next word as soon as the current one leaves
    assign fetch_address = fire ? pc + 1'b1 : pc;

    assign issue.valid = fire;
    assign issue.word  = fetch_word;

    ////////////////////////////////////////
    // Run control and program counter

    always_ff @(posedge clock) begin
        if (reset) begin
            running     <= 1'b0;
            fetch_valid <= 1'b0;
            pc          <= '0;
        end else if (run) begin
            running     <= 1'b1;
            fetch_valid <= 1'b0;
            pc          <= '0;
        end else begin
            // HALT is the last word sent
            if (fire_halt) begin
                running <= 1'b0;
            end
            fetch_valid <= running && !fire_halt;
            if (fire) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // Spend one per issue, regain one per queue pop
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CREDIT_WIDTH'(`CORE_QUEUE_DEPTH);
        end else begin
            case ({fire, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Returned credits never exceed what the queue can hold
    credit_bound: assert property (@(posedge clock) disable iff (reset)
        credits <= `CORE_QUEUE_DEPTH)
        else $error("credit counter above queue depth: %0d", credits);

endmodule

// ==== source/issue_queue.sv ====
// Credit-sized issue FIFO between control and execute, one credit back per pop
`include "core_defines.svh"

module issue_queue (
    input  logic             clock,
    input  logic             reset,
    input  core_pkg::issue_t issue,
    input  logic             pop,
    output core_pkg::issue_t head,
    output logic             credit_return
);

    // Depth is a power of two so pointers wrap on their own
    localparam int PTR_WIDTH = $clog2(`CORE_QUEUE_DEPTH);

    core_pkg::instruction_t slots [`CORE_QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] write_ptr;
    logic [PTR_WIDTH-1:0] read_ptr;
    logic [PTR_WIDTH:0]   count;
    logic                 push;
    logic                 pop_fire;
    logic                 full;

    assign push     = issue.valid;
    assign pop_fire = pop && head.valid;
    assign full     = (count == `CORE_QUEUE_DEPTH);

    assign head.valid    = (count != '0);
    assign head.word     = slots[read_ptr];
    assign credit_return = pop_fire;

    always_ff @(posedge clock) begin
        if (push) begin
            slots[write_ptr] <= issue.word;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (push) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (pop_fire) begin
                read_ptr <= read_ptr + 1'b1;
            end
            case ({push, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The producer's credits should make this impossible
    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        issue.valid |-> !full)
        else $error("issue pushed into a full queue, credit violation");

endmodule

// ==== source/register_file.sv ====
// Sixteen data registers with two combinational reads and one write port
`include "core_defines.svh"

module register_file (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_a,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_b,
    output logic [`CORE_DATA_WIDTH-1:0]     read_data_a,
    output logic [`CORE_DATA_WIDTH-1:0]     read_data_b,
    input  core_pkg::result_t               write
);

    logic [`CORE_DATA_WIDTH-1:0] registers [`CORE_REG_COUNT];

    ////////////////////////////////////////
    // Write port

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (write.valid) begin
            registers[write.dest] <= write.data;
        end
    end

    ////////////////////////////////////////
    // Read ports

    // No write-through here, the execute unit bypasses same-cycle writes
    assign read_data_a = registers[read_addr_a];
    assign read_data_b = registers[read_addr_b];

endmodule

// ==== source/execute_unit.sv ====
// Execute unit with decode, operand read and bypass, ALU, writeback, done and fault
`include "core_defines.svh"

module execute_unit (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            run,
    input  logic                            hold,
    input  core_pkg::issue_t                head,
    output logic                            pop,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_a,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_b,
    input  logic [`CORE_DATA_WIDTH-1:0]     read_data_a,
    input  logic [`CORE_DATA_WIDTH-1:0]     read_data_b,
    output core_pkg::result_t               result,
    output logic                            done,
    output logic                            fault
);

    logic [`CORE_DATA_WIDTH-1:0]     capture_a;
    logic [`CORE_DATA_WIDTH-1:0]     capture_b;
    logic                            s1_valid;
    core_pkg::instruction_t          s1_word;
    logic [`CORE_DATA_WIDTH-1:0]     s1_a;
    logic [`CORE_DATA_WIDTH-1:0]     s1_b;
    core_pkg::opcode_t               s1_opcode;
    logic [`CORE_DATA_WIDTH-1:0]     operand_a;
    logic [`CORE_DATA_WIDTH-1:0]     operand_b;
    logic [`CORE_DATA_WIDTH-1:0]     alu_data;
    logic                            alu_write;
    logic                            is_halt;
    logic                            is_illegal;
    logic                            wb_valid;
    logic [`CORE_REG_ADDR_WIDTH-1:0] wb_dest;
    logic [`CORE_DATA_WIDTH-1:0]     wb_data;

    ////////////////////////////////////////
    // Stage 1 pop and operand read

    assign pop         = head.valid && !hold;
    assign read_addr_a = head.word.reg_form.src_a;
    assign read_addr_b = head.word.reg_form.src_b;

    // Writeback landing this cycle is not yet visible in the register file
    assign capture_a = (wb_valid && wb_dest == read_addr_a) ? wb_data : read_data_a;
    assign capture_b = (wb_valid && wb_dest == read_addr_b) ? wb_data : read_data_b;

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pop;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            s1_word <= head.word;
            s1_a    <= capture_a;
            s1_b    <= capture_b;
        end
    end

    ////////////////////////////////////////
    // Stage 2 ALU and writeback

    assign s1_opcode = core_pkg::opcode_t'(s1_word.reg_form.opcode);

    // Previous result was not ready when this word was captured
    assign operand_a = (wb_valid && wb_dest == s1_word.reg_form.src_a) ? wb_data : s1_a;
    assign operand_b = (wb_valid && wb_dest == s1_word.reg_form.src_b) ? wb_data : s1_b;

    always_comb begin
        alu_data   = '0;
        alu_write  = 1'b1;
        is_halt    = 1'b0;
        is_illegal = 1'b0;
        case (s1_opcode)
            core_pkg::NOP:  alu_write = 1'b0;
            core_pkg::ADD:  alu_data = operand_a + operand_b;
            core_pkg::SUB:  alu_data = operand_a - operand_b;
            core_pkg::AND:  alu_data = operand_a & operand_b;
            core_pkg::OR:   alu_data = operand_a | operand_b;
            core_pkg::XOR:  alu_data = operand_a ^ operand_b;
            core_pkg::SHL:  alu_data = operand_a << operand_b[3:0];
            core_pkg::LDI:  alu_data = s1_word.imm_form.immediate;
            core_pkg::HALT: begin
                alu_write = 1'b0;
                is_halt   = 1'b1;
            end
            default: begin
                alu_write  = 1'b0;
                is_illegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
            done     <= 1'b0;
            fault    <= 1'b0;
        end else begin
            wb_valid <= s1_valid && alu_write;
            if (run) begin
                done  <= 1'b0;
                fault <= 1'b0;
            end else begin
                if (s1_valid && is_halt) begin
                    done <= 1'b1;
                end
                if (s1_valid && is_illegal) begin
                    fault <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        wb_dest <= s1_word.reg_form.dest;
        wb_data <= alu_data;
    end

    assign result.valid = wb_valid;
    assign result.dest  = wb_dest;
    assign result.data  = wb_data;

    // A head word that is waiting for its pop stays in place
    head_stable: assert property (@(posedge clock) disable iff (reset)
        head.valid && !pop |=> head.valid && $stable(head.word))
        else $error("queue head changed while waiting to be popped");

endmodule

// ==== source/core_top.sv ====
// Top level joining instruction store, control, issue queue, execute and register file
`include "core_defines.svh"

module core_top (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      run,
    input  logic                      hold,
    input  logic                      load_valid,
    input  logic [`CORE_PC_WIDTH-1:0] load_address,
    input  core_pkg::instruction_t    load_word,
    output core_pkg::result_t         result,
    output logic                      done,
    output logic                      fault
);

    logic [`CORE_PC_WIDTH-1:0]       fetch_address;
    core_pkg::instruction_t          fetch_word;
    core_pkg::issue_t                issue;
    core_pkg::issue_t                head;
    logic                            credit_return;
    logic                            pop;
    logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_a;
    logic [`CORE_REG_ADDR_WIDTH-1:0] read_addr_b;
    logic [`CORE_DATA_WIDTH-1:0]     read_data_a;
    logic [`CORE_DATA_WIDTH-1:0]     read_data_b;

    ////////////////////////////////////////
    // Front end

    instruction_store store (
        .clock(clock),
        .load_valid(load_valid),
        .load_address(load_address),
        .load_word(load_word),
        .fetch_address(fetch_address),
        .fetch_word(fetch_word)
    );

    control_unit control (
        .clock(clock),
        .reset(reset),
        .run(run),
        .fetch_address(fetch_address),
        .fetch_word(fetch_word),
        .credit_return(credit_return),
        .issue(issue)
    );

    issue_queue queue (
        .clock(clock),
        .reset(reset),
        .issue(issue),
        .pop(pop),
        .head(head),
        .credit_return(credit_return)
    );

    ////////////////////////////////////////
    // Back end

    execute_unit executor (
        .clock(clock),
        .reset(reset),
        .run(run),
        .hold(hold),
        .head(head),
        .pop(pop),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .result(result),
        .done(done),
        .fault(fault)
    );

    // Writeback goes to both the registers and the result port
    register_file registers (
        .clock(clock),
        .reset(reset),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .write(result)
    );

endmodule

// ==== tests/core_tb.sv ====
// Testbench for core_top with stimulus file reader, program load, random hold, checker, watchdog
`include "core_defines.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STIMULUS_DEPTH = 256;

    logic                            clock;
    logic                            reset;
    logic                            run;
    logic                            hold;
    logic                            load_valid;
    logic [`CORE_PC_WIDTH-1:0]       load_address;
    core_pkg::instruction_t          load_word;
    core_pkg::result_t               result;
    logic                            done;
    logic                            fault;

    logic [`CORE_INSTR_WIDTH-1:0]    stimulus [STIMULUS_DEPTH];
    int                              cursor;
    int                              watchdog_cycles;
    int                              error_count;
    int                              failed_tests;
    logic [15:0]                     lfsr_state;
    logic [`CORE_REG_ADDR_WIDTH-1:0] seen_dest [$];
    logic [`CORE_DATA_WIDTH-1:0]     seen_data [$];
    logic                            late_result;

    core_top UUT (
        .clock(clock),
        .reset(reset),
        .run(run),
        .hold(hold),
        .load_valid(load_valid),
        .load_address(load_address),
        .load_word(load_word),
        .result(result),
        .done(done),
        .fault(fault)
    );

    always #2 clock = ~clock;

    ////////////////////////////////////////
    // Helpers

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end else begin
            return state >> 1;
        end
    endfunction

    // Hold only when two fresh bits are both set
    task automatic draw_hold(input logic stalled);
        logic first;
        logic second;
        if (stalled) begin
            lfsr_state = lfsr_step(lfsr_state);
            first      = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
            second     = lfsr_state[0];
            hold       = first && second;
        end else begin
            hold = 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic read_entry(output logic [`CORE_INSTR_WIDTH-1:0] value);
        value = stimulus[cursor];
        cursor++;
    endtask

    // First pass over the file, only to size the watchdog
    task automatic count_program_words(input int test_count, output int total);
        logic [`CORE_INSTR_WIDTH-1:0] value;
        int                           words;
        total = 0;
        for (int t = 0; t < test_count; t++) begin
            cursor++;
            read_entry(value);
            words = int'(value);
            total += words;
            cursor += words;
            read_entry(value);
            cursor += 2 * int'(value) + 1;
        end
    endtask

    ////////////////////////////////////////
    // Result monitor

    always @(negedge clock) begin
        if (!reset && result.valid) begin
            seen_dest.push_back(result.dest);
            seen_data.push_back(result.data);
            if (done) begin
                late_result = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // One test from the file

    task automatic run_test(input int number);
        logic [`CORE_INSTR_WIDTH-1:0]    value;
        logic                            stalled;
        logic                            expect_fault;
        int                              words;
        int                              writebacks;
        int                              errors_before;
        string                           mode;
        logic [`CORE_REG_ADDR_WIDTH-1:0] expect_dest [$];
        logic [`CORE_DATA_WIDTH-1:0]     expect_data [$];

        errors_before = error_count;
        read_entry(value);
        stalled = value[0];
        read_entry(value);
        words = int'(value);
        // Program load while the core is idle
        for (int i = 0; i < words; i++) begin
            read_entry(value);
            load_valid   = 1'b1;
            load_address = i[`CORE_PC_WIDTH-1:0];
            load_word    = value;
            @(negedge clock);
        end
        load_valid = 1'b0;
        read_entry(value);
        writebacks = int'(value);
        for (int i = 0; i < writebacks; i++) begin
            read_entry(value);
            expect_dest.push_back(value[`CORE_REG_ADDR_WIDTH-1:0]);
            read_entry(value);
            expect_data.push_back(value[`CORE_DATA_WIDTH-1:0]);
        end
        read_entry(value);
        expect_fault = value[0];

        seen_dest.delete();
        seen_data.delete();
        late_result = 1'b0;
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
        while (!done) begin
            draw_hold(stalled);
            @(negedge clock);
        end
        hold = 1'b0;
        // Quiet window after done
        repeat (8) @(negedge clock);

        check_value("writeback count", seen_dest.size(), expect_dest.size());
        for (int i = 0; i < writebacks && i < seen_dest.size(); i++) begin
            check_value($sformatf("result.dest[%0d]", i), seen_dest[i], expect_dest[i]);
            check_value($sformatf("result.data[%0d]", i), seen_data[i], expect_data[i]);
        end
        check_value("fault", fault, expect_fault);
        if (late_result) begin
            $display("A result was written back after done rose in test %0d", number);
            error_count++;
        end
        if (error_count != errors_before) begin
            failed_tests++;
        end
        mode = stalled ? "with hold" : "no hold";
        $display("test %0d (%s): %0d writebacks, %0d errors", number, mode,
                 seen_dest.size(), error_count - errors_before);
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        int test_count;
        int total_words;
        clock        = 1'b0;
        reset        = 1'b1;
        run          = 1'b0;
        hold         = 1'b0;
        load_valid   = 1'b0;
        load_address = '0;
        load_word    = '0;
        error_count  = 0;
        failed_tests = 0;
        late_result  = 1'b0;
        lfsr_state   = 16'd46;
        test_count   = 0;
        $readmemh("tests/core_stimulus.txt", stimulus);
        if ($isunknown(stimulus[0])) begin
            $display("The stimulus file could not be read");
            error_count++;
        end else begin
            test_count = int'(stimulus[0]);
        end
        cursor = 1;
        count_program_words(test_count, total_words);
        cursor          = 1;
        watchdog_cycles = 40 * total_words + 100;

        repeat (5) @(negedge clock);
        reset = 1'b0;
        check_value("done", done, 1'b0);
        check_value("fault", fault, 1'b0);
        check_value("result.valid", result.valid, 1'b0);

        for (int t = 0; t < test_count; t++) begin
            run_test(t + 1);
        end

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the program lengths in the file
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout after %0d clock cycles, a program never finished", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/core_pkg.sv
source/instruction_store.sv
source/control_unit.sv
source/issue_queue.sv
source/register_file.sv
source/execute_unit.sv
source/core_top.sv
tests/core_tb.sv

// ==== tests/core_stimulus.txt ====
// Columns: test count first, then per test the hold flag, program word count, program words,
// writeback count, dest and data pairs in writeback order, expected fault flag (all hex)
5
// Arithmetic and logic, LDI then ADD SUB AND OR XOR SHL
0 0A
7112F0 720F3C 131200 242100 351200 461200 571200 780008 692800 F00000
09
1 12F0 2 0F3C 3 222C 4 FC4C 5 0230 6 1FFC 7 1DCC 8 0008 9 3C00
0
// Dependency chain, each instruction reads the previous destination
0 08
710003 111100 121100 232100 533200 643100 444300 F00000
07
1 0003 1 0006 2 000C 3 0006 3 000A 4 0280 4 028A
0
// Illegal opcode 9 between legal instructions, NOP writes nothing
0 07
710010 720005 931200 141200 000000 251200 F00000
04
1 0010 2 0005 4 0015 5 000B
1
// Arithmetic program again under random hold
1 0A
7112F0 720F3C 131200 242100 351200 461200 571200 780008 692800 F00000
09
1 12F0 2 0F3C 3 222C 4 FC4C 5 0230 6 1FFC 7 1DCC 8 0008 9 3C00
0
// Dependency chain again under random hold
1 08
710003 111100 121100 232100 533200 643100 444300 F00000
07
1 0003 1 0006 2 000C 3 0006 3 000A 4 0280 4 028A
0
